//--- source/display_pkg.sv
`default_nettype none

package display_pkg;

    localparam int hor_active_pixels = 640;
    localparam int ver_active_pixels = 480;

    localparam int x_width = $clog2(hor_active_pixels);
    localparam int y_width = $clog2(ver_active_pixels);

    // polyline starts here, symbols swing around it.
    localparam int trace_center = ver_active_pixels / 2;
    localparam int symbol_bias  = 64;

    localparam int x_step       = 8;
    localparam int max_segments = hor_active_pixels / x_step - 1;

    typedef struct packed {
        logic [x_width-1:0] x;
        logic [y_width-1:0] y;
    } point_t;

    typedef struct packed {
        point_t p1;  // start point.
        point_t p2;  // end point.
    } segment_t;

endpackage

`default_nettype wire

//--- source/text_pkg.sv
`default_nettype none

package text_pkg;

    localparam int symbol_width   = 7;
    localparam int message_length = 12;
    localparam int index_width    = $clog2(message_length + 1);

    // ascii codes, first entry drawn first.
    localparam logic [symbol_width-1:0] message [message_length] = '{
        7'h48,  // H.
        7'h45,  // E.
        7'h4c,  // L.
        7'h4c,  // L.
        7'h4f,  // O.
        7'h2c,  // comma.
        7'h20,  // space.
        7'h57,  // W.
        7'h4f,  // O.
        7'h52,  // R.
        7'h4c,  // L.
        7'h44   // D.
    };

endpackage

`default_nettype wire

//--- source/symbol_iterator.sv
`default_nettype none

module symbol_iterator
    import text_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    symbol_iter_start,
    input  logic                    symbol_iter_en,
    output logic [symbol_width-1:0] symbol,
    output logic                    symbol_valid
);

    logic [index_width-1:0] index;

    // Index parks at message_length once the text is used up,
    // so symbol_valid stays low until the next rewind.
    assign symbol_valid = (index < message_length);

    always_comb begin
        if (symbol_valid) begin
            symbol = message[index];
        end else begin
            symbol = '0;  // past the end.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            index <= '0;
        end else if (symbol_iter_start) begin
            index <= '0;  // rewind.
        end else if (symbol_iter_en && symbol_valid) begin
            index <= index + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/line_drawer.sv
`default_nettype none

module line_drawer
    import display_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  segment_t segment,
    input  logic     line_drawer_start,
    output logic     line_drawer_ready,
    output point_t   pixel,
    output logic     pixel_valid
);

    // absolute deltas of the incoming segment.
    logic [x_width-1:0] abs_dx;
    logic [y_width-1:0] abs_dy;
    logic               x_back;
    logic               y_back;

    // latched stepping state, signed with headroom for twice the error.
    logic signed [x_width+2:0] dx;
    logic signed [x_width+2:0] dy;
    logic signed [x_width+2:0] err;
    logic signed [x_width+2:0] e2;
    logic signed [x_width+2:0] err_next;
    logic                      step_x;
    logic                      step_y;
    logic                      x_neg;
    logic                      y_neg;
    point_t                    p2;
    logic                      last;
    logic                      accept;

    assign line_drawer_ready = ~pixel_valid;
    assign accept            = line_drawer_start && !pixel_valid;

    assign x_back = (segment.p2.x < segment.p1.x);
    assign y_back = (segment.p2.y < segment.p1.y);

    always_comb begin
        if (x_back) begin
            abs_dx = segment.p1.x - segment.p2.x;
        end else begin
            abs_dx = segment.p2.x - segment.p1.x;
        end

        if (y_back) begin
            abs_dy = segment.p1.y - segment.p2.y;
        end else begin
            abs_dy = segment.p2.y - segment.p1.y;
        end
    end

    // Bresenham step decision for the current point.
    always_comb begin
        e2       = err <<< 1;
        step_x   = (e2 >= dy);
        step_y   = (e2 <= dx);
        err_next = err;
        if (step_x) begin
            err_next = err_next + dy;
        end
        if (step_y) begin
            err_next = err_next + dx;
        end
    end

    assign last = (pixel == p2);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pixel_valid <= 1'b0;
        end else if (accept) begin
            pixel_valid <= 1'b1;
        end else if (pixel_valid && last) begin
            pixel_valid <= 1'b0;  // p2 was just shown.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pixel <= segment.p1;
            p2    <= segment.p2;
            x_neg <= x_back;
            y_neg <= y_back;
            dx    <= $signed({3'b000, abs_dx});
            dy    <= -$signed({4'b0000, abs_dy});
            err   <= $signed({3'b000, abs_dx}) - $signed({4'b0000, abs_dy});
        end else if (pixel_valid && !last) begin
            if (step_x) begin
                if (x_neg) begin
                    pixel.x <= pixel.x - 1'b1;
                end else begin
                    pixel.x <= pixel.x + 1'b1;
                end
            end
            if (step_y) begin
                if (y_neg) begin
                    pixel.y <= pixel.y - 1'b1;
                end else begin
                    pixel.y <= pixel.y + 1'b1;
                end
            end
            err <= err_next;
        end
    end

endmodule

`default_nettype wire

//--- source/trace_planner.sv
`default_nettype none

module trace_planner
    import display_pkg::*;
    import text_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    start,
    output logic                    ready,
    output segment_t                segment,
    output logic                    line_drawer_start,
    input  logic                    line_drawer_ready,
    output logic                    symbol_iter_start,
    output logic                    symbol_iter_en,
    input  logic [symbol_width-1:0] symbol,
    input  logic                    symbol_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_draw,
        st_wait_1,
        st_wait_2
    } state_t;

    localparam point_t start_point = '{x: '0, y: y_width'(trace_center)};

    state_t             state;
    logic [x_width-1:0] count;  // segments issued so far.
    logic               take;
    point_t             next_p2;

    assign ready = (state == st_idle);

    // rewind happens on the same edge that leaves idle.
    assign symbol_iter_start = ready && start;

    assign take = symbol_valid && (count < max_segments);

    // height of the new endpoint follows the symbol code.
    always_comb begin
        next_p2.x = x_width'(count * x_step);
        next_p2.y = y_width'(trace_center - symbol_bias + symbol);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state             <= st_idle;
            count             <= '0;
            line_drawer_start <= 1'b0;
            symbol_iter_en    <= 1'b0;
        end else begin
            line_drawer_start <= 1'b0;
            symbol_iter_en    <= 1'b0;

            case (state)
                st_idle: begin
                    if (start) begin
                        count <= '0;
                        state <= st_draw;
                    end
                end
                st_draw: begin
                    if (take) begin
                        line_drawer_start <= 1'b1;
                        symbol_iter_en    <= 1'b1;
                        count             <= count + 1'b1;
                        state             <= st_wait_1;
                    end else begin
                        state <= st_idle;  // message done or screen full.
                    end
                end
                st_wait_1: begin
                    state <= st_wait_2;  // drawer drops ready here.
                end
                st_wait_2: begin
                    if (line_drawer_ready) begin
                        state <= st_draw;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // segment chain, each new segment starts where the last one ended.
    always_ff @(posedge clk) begin
        if (symbol_iter_start) begin
            segment.p2 <= start_point;
        end else if (state == st_draw && take) begin
            segment.p1 <= segment.p2;
            segment.p2 <= next_p2;
        end
    end

endmodule

`default_nettype wire

//--- source/trace_plotter.sv
`default_nettype none

module trace_plotter
    import display_pkg::*;
    import text_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   start,
    output logic   ready,
    output point_t pixel,
    output logic   pixel_valid
);

    segment_t                segment;
    logic                    line_drawer_start;
    logic                    line_drawer_ready;
    logic                    symbol_iter_start;
    logic                    symbol_iter_en;
    logic [symbol_width-1:0] symbol;
    logic                    symbol_valid;

    trace_planner i_trace_planner (
        .clk               (clk),
        .arst_n            (arst_n),
        .start             (start),
        .ready             (ready),
        .segment           (segment),
        .line_drawer_start (line_drawer_start),
        .line_drawer_ready (line_drawer_ready),
        .symbol_iter_start (symbol_iter_start),
        .symbol_iter_en    (symbol_iter_en),
        .symbol            (symbol),
        .symbol_valid      (symbol_valid)
    );

    symbol_iterator i_symbol_iterator (
        .clk               (clk),
        .arst_n            (arst_n),
        .symbol_iter_start (symbol_iter_start),
        .symbol_iter_en    (symbol_iter_en),
        .symbol            (symbol),
        .symbol_valid      (symbol_valid)
    );

    line_drawer i_line_drawer (
        .clk               (clk),
        .arst_n            (arst_n),
        .segment           (segment),
        .line_drawer_start (line_drawer_start),
        .line_drawer_ready (line_drawer_ready),
        .pixel             (pixel),
        .pixel_valid       (pixel_valid)
    );

endmodule

`default_nettype wire

//--- test/trace_plotter_tests.svh
`ifndef trace_plotter_tests_svh
`define trace_plotter_tests_svh

// one Bresenham walk per message symbol with chained endpoints.
function automatic void build_expected_pixels();
    int     x0;
    int     y0;
    int     x1;
    int     y1;
    int     dx;
    int     dy;
    int     sx;
    int     sy;
    int     err;
    int     e2;
    int     x;
    int     y;
    logic   done;
    point_t pt;
    x0 = 0;
    y0 = trace_center;
    expected.delete();
    for (int i = 0; i < message_length && i < max_segments; i++) begin
        x1  = i * x_step;
        y1  = trace_center + int'(message[i]) - symbol_bias;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;  // minus the magnitude.
        sx  = (x1 >= x0) ? 1 : -1;
        sy  = (y1 >= y0) ? 1 : -1;
        err = dx + dy;
        x   = x0;
        y   = y0;
        done = 1'b0;
        while (!done) begin
            pt.x = x_width'(x);
            pt.y = y_width'(y);
            expected.push_back(pt);
            if (x == x1 && y == y1) begin
                done = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err += dy;
                    x   += sx;
                end
                if (e2 <= dx) begin
                    err += dx;
                    y   += sy;
                end
            end
        end
        x0 = x1;
        y0 = y1;
    end
endfunction

task automatic compare_stream(input string name);
    assert (captured.size() == expected.size())
    else stop_on_error($sformatf("mismatch %s: pixel count expected %0d actual %0d",
                                 name, expected.size(), captured.size()));
    foreach (expected[i]) begin
        assert (captured[i] == expected[i])
        else stop_on_error($sformatf(
            "mismatch %s: pixel %0d expected (%0d,%0d) actual (%0d,%0d)",
            name, i, expected[i].x, expected[i].y, captured[i].x, captured[i].y));
    end
endtask

// nothing may trickle out once ready is back.
task automatic confirm_idle(input string name);
    int count;
    count = captured.size();
    repeat (20) begin
        next_cycle();
        assert (pixel_valid === 1'b0)
        else stop_on_error($sformatf("mismatch %s: pixel_valid after run expected 0 actual %b",
                                     name, pixel_valid));
        assert (ready === 1'b1)
        else stop_on_error($sformatf("mismatch %s: ready after run expected 1 actual %b",
                                     name, ready));
    end
    assert (captured.size() == count)
    else stop_on_error($sformatf("mismatch %s: pixels after run expected 0 actual %0d",
                                 name, captured.size() - count));
endtask

task automatic verify_reset_state();
    assert (ready === 1'b1)
    else stop_on_error($sformatf("mismatch reset_state: ready expected 1 actual %b", ready));
    assert (pixel_valid === 1'b0)
    else stop_on_error($sformatf("mismatch reset_state: pixel_valid expected 0 actual %b",
                                 pixel_valid));
    repeat (10) next_cycle();
    assert (captured.size() == 0)
    else stop_on_error($sformatf("mismatch reset_state: pixels expected 0 actual %0d",
                                 captured.size()));
endtask

task automatic run_full_trace();
    int last_x;
    int last_y;
    last_x = (message_length - 1) * x_step;
    last_y = trace_center + int'(message[message_length - 1]) - symbol_bias;
    launch_run("full_run");
    wait_for_ready("full_run");
    compare_stream("full_run");
    assert (captured[0].x == 0 && captured[0].y == trace_center)
    else stop_on_error($sformatf(
        "mismatch full_run: first pixel expected (0,%0d) actual (%0d,%0d)",
        trace_center, captured[0].x, captured[0].y));
    assert (captured[$].x == last_x && captured[$].y == last_y)
    else stop_on_error($sformatf(
        "mismatch full_run: last pixel expected (%0d,%0d) actual (%0d,%0d)",
        last_x, last_y, captured[$].x, captured[$].y));
    confirm_idle("full_run");
endtask

task automatic ignore_busy_start();
    launch_run("start_while_busy");
    repeat (40) next_cycle();
    assert (ready === 1'b0)
    else stop_on_error("start_while_busy: the run ended before the second start");
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    wait_for_ready("start_while_busy");
    compare_stream("start_while_busy");
    confirm_idle("start_while_busy");
endtask

task automatic repeat_trace();
    launch_run("second_run");
    wait_for_ready("second_run");
    compare_stream("second_run");
    confirm_idle("second_run");
endtask

task automatic reset_mid_trace();
    int cycles;
    int frozen;
    launch_run("mid_run_reset");
    cycles = 0;
    while (captured.size() < 60) begin
        next_cycle();
        cycles++;
        assert (cycles <= run_cycles)
        else stop_on_error("mid_run_reset: too few pixels came out before the reset");
    end
    arst_n = 1'b0;
    next_cycle();
    assert (ready === 1'b1)
    else stop_on_error($sformatf("mismatch mid_run_reset: ready in reset expected 1 actual %b",
                                 ready));
    assert (pixel_valid === 1'b0)
    else stop_on_error($sformatf(
        "mismatch mid_run_reset: pixel_valid in reset expected 0 actual %b", pixel_valid));
    frozen = captured.size();
    repeat (reset_cycles - 1) next_cycle();
    arst_n = 1'b1;
    assert (captured.size() == frozen)
    else stop_on_error($sformatf("mismatch mid_run_reset: pixels in reset expected 0 actual %0d",
                                 captured.size() - frozen));
    launch_run("after_reset");
    wait_for_ready("after_reset");
    compare_stream("after_reset");
    confirm_idle("after_reset");
endtask

`endif

//--- test/trace_plotter_tb.sv
`default_nettype none

module trace_plotter_tb
    import display_pkg::*;
    import text_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period     = 100;
    localparam int stim_delay     = 10;
    localparam int reset_cycles   = 5;
    localparam int run_cycles     = 280;  // one full trace plus slack.
    localparam int run_count      = 5;
    localparam int timeout_cycles = run_count * run_cycles + 100;

    logic   clk;
    logic   arst_n;
    logic   start;
    logic   ready;
    point_t pixel;
    logic   pixel_valid;

    point_t captured[$];
    point_t expected[$];

    trace_plotter i_trace_plotter (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .ready       (ready),
        .pixel       (pixel),
        .pixel_valid (pixel_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (pixel_valid === 1'b1) begin
            captured.push_back(pixel);
        end
    end

    initial begin
        #(timeout_cycles * clk_period);
        stop_on_error("timeout: the test sequence did not finish in time");
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #stim_delay;
    endtask

    task automatic launch_run(input string name);
        captured.delete();
        next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        assert (ready === 1'b0)
        else stop_on_error($sformatf("mismatch %s: ready after start expected 0 actual %b",
                                     name, ready));
    endtask

    task automatic wait_for_ready(input string name);
        int cycles;
        cycles = 0;
        while (ready !== 1'b1) begin
            next_cycle();
            cycles++;
            assert (cycles <= run_cycles)
            else stop_on_error($sformatf("%s: ready did not return within %0d cycles",
                                         name, run_cycles));
        end
    endtask

    `include "trace_plotter_tests.svh"

    initial begin
        arst_n = 1'b0;
        start  = 1'b0;
        build_expected_pixels();
        repeat (reset_cycles) next_cycle();
        arst_n = 1'b1;

        verify_reset_state();
        run_full_trace();
        ignore_busy_start();
        repeat_trace();
        reset_mid_trace();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- trace_plotter.f
+incdir+test
source/display_pkg.sv
source/text_pkg.sv
source/symbol_iterator.sv
source/line_drawer.sv
source/trace_planner.sv
source/trace_plotter.sv
test/trace_plotter_tb.sv
